/* src/csrPkg.sv */
`default_nettype none

package csrPkg;

    localparam int XLEN = 32;
    localparam int CSR_ADDR_W = 12;
    localparam int CAUSE_W = 5;
    localparam int RETIRE_W = 2;  // up to two retires per cycle
    localparam logic [XLEN-1:0] RESET_VECTOR = 32'h8000_0000;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [CSR_ADDR_W-1:0] csrAddr_t;

    typedef enum logic [CSR_ADDR_W-1:0] {
        csrMstatus       = 12'h300,
        csrMie           = 12'h304,
        csrMtvec         = 12'h305,
        csrMcounteren    = 12'h306,
        csrMcountinhibit = 12'h320,
        csrMscratch      = 12'h340,
        csrMepc          = 12'h341,
        csrMcause        = 12'h342,
        csrMtval         = 12'h343,
        csrMip           = 12'h344,
        csrMcycle        = 12'hB00,
        csrMinstret      = 12'hB02,
        csrMcycleh       = 12'hB80,
        csrMinstreth     = 12'hB82,
        csrCycle         = 12'hC00,
        csrInstret       = 12'hC02,
        csrCycleh        = 12'hC80,
        csrInstreth      = 12'hC82
    } csrAddrs_e;

    typedef enum logic [2:0] {
        opRead,
        opReadWrite,
        opReadSet,
        opReadClear,
        opReadWriteImm,
        opReadSetImm,
        opReadClearImm,
        opMret
    } csrOp_e;

    typedef enum logic [1:0] {
        flagsNone,
        flagsOrdering,
        flagsXret,
        flagsIllegal
    } resFlags_e;

    typedef enum logic [1:0] {
        privUser    = 2'd0,
        privMachine = 2'd3
    } privLevel_e;

    // interrupt bits in mie / mip
    localparam int MSI_BIT = 3;
    localparam int MTI_BIT = 7;
    localparam int MEI_BIT = 11;
    localparam word_t IRQ_MASK = (word_t'(1) << MSI_BIT) | (word_t'(1) << MTI_BIT)
                               | (word_t'(1) << MEI_BIT);

    // mstatus fields
    localparam int MSTATUS_MIE_BIT = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LO = 11;

    // counter enable / inhibit bits
    localparam int CY_BIT = 0;
    localparam int IR_BIT = 2;

    // exception causes that report an mtval
    localparam logic [CAUSE_W-1:0] CAUSE_FETCH_AF = 5'd1;
    localparam logic [CAUSE_W-1:0] CAUSE_BREAK = 5'd3;
    localparam logic [CAUSE_W-1:0] CAUSE_LOAD_MA = 5'd4;
    localparam logic [CAUSE_W-1:0] CAUSE_LOAD_AF = 5'd5;
    localparam logic [CAUSE_W-1:0] CAUSE_STORE_MA = 5'd6;
    localparam logic [CAUSE_W-1:0] CAUSE_STORE_AF = 5'd7;
    localparam logic [CAUSE_W-1:0] CAUSE_FETCH_PF = 5'd12;
    localparam logic [CAUSE_W-1:0] CAUSE_LOAD_PF = 5'd13;
    localparam logic [CAUSE_W-1:0] CAUSE_STORE_PF = 5'd15;

endpackage

`default_nettype wire

/* src/privControl.sv */
`timescale 1ns/1ps
`default_nettype none

module privControl import csrPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       trapValid,
    input  logic       trapIsInterrupt,
    input  logic       mretEn,
    input  logic       wrEn,
    input  csrAddr_t   wrAddr,
    input  word_t      wrData,
    output privLevel_e priv,
    output logic       mstatusMie,
    output word_t      mstatusVal
);

    logic mpie;
    privLevel_e mpp;
    logic trapTaken;

    // interrupts only while globally enabled
    assign trapTaken = trapValid && (!trapIsInterrupt || priv == privUser || mstatusMie);

    always_ff @(posedge clk) begin
        if (rst) begin
            priv <= privMachine;
            mstatusMie <= 1'b0;
            mpie <= 1'b0;
            mpp <= privUser;
        end else if (trapTaken) begin
            mpie <= mstatusMie;
            mstatusMie <= 1'b0;
            mpp <= priv;
            priv <= privMachine;
        end else if (mretEn) begin
            mstatusMie <= mpie;
            mpie <= 1'b1;
            priv <= mpp;
            mpp <= privUser;
        end else if (wrEn && wrAddr == csrMstatus) begin
            mstatusMie <= wrData[MSTATUS_MIE_BIT];
            mpie <= wrData[MSTATUS_MPIE_BIT];
            // no supervisor level here so 1 and 2 read back as user
            mpp <= (wrData[MSTATUS_MPP_LO +: 2] == 2'b11) ? privMachine : privUser;
        end
    end

    always_comb begin
        mstatusVal = '0;
        mstatusVal[MSTATUS_MIE_BIT] = mstatusMie;
        mstatusVal[MSTATUS_MPIE_BIT] = mpie;
        mstatusVal[MSTATUS_MPP_LO +: 2] = mpp;
    end

endmodule

`default_nettype wire

/* src/cycleCounters.sv */
`timescale 1ns/1ps
`default_nettype none

module cycleCounters import csrPkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic [RETIRE_W-1:0] retireCount,
    input  logic                wrEn,
    input  csrAddr_t            wrAddr,
    input  word_t               wrData,
    output logic [1:0]          inhibit,   // {ir, cy}
    output logic [63:0]         mcycle,
    output logic [63:0]         minstret
);

    // a csr write to a half wins over counting for that cycle
    function automatic logic [63:0] nextCount(input logic [63:0] cur, input logic [63:0] inc,
                                              input logic hold, input logic wrLo,
                                              input logic wrHi, input word_t data);
        logic [63:0] next;
        next = hold ? cur : cur + inc;
        if (wrLo)
            next = {cur[63:XLEN], data};
        if (wrHi)
            next = {data, cur[XLEN-1:0]};
        return next;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            inhibit <= 2'b00;
            mcycle <= '0;
            minstret <= '0;
        end else begin
            if (wrEn && wrAddr == csrMcountinhibit)
                inhibit <= {wrData[IR_BIT], wrData[CY_BIT]};
            mcycle <= nextCount(mcycle, 64'd1, inhibit[0],
                                wrEn && wrAddr == csrMcycle, wrEn && wrAddr == csrMcycleh, wrData);
            minstret <= nextCount(minstret, 64'(retireCount), inhibit[1],
                                  wrEn && wrAddr == csrMinstret, wrEn && wrAddr == csrMinstreth,
                                  wrData);
        end
    end

endmodule

`default_nettype wire

/* src/trapRegs.sv */
`timescale 1ns/1ps
`default_nettype none

module trapRegs import csrPkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               trapValid,
    input  logic [CAUSE_W-1:0] trapCause,
    input  logic               trapIsInterrupt,
    input  word_t              trapPc,
    input  word_t              trapTval,
    input  logic               irqExt,
    input  logic               irqTimer,
    input  logic               mretEn,
    input  logic               wrEn,
    input  csrAddr_t           wrAddr,
    input  word_t              wrData,
    input  privLevel_e         priv,
    input  logic               mstatusMie,
    output word_t              mtvecVal,
    output word_t              mepcVal,
    output word_t              mcauseVal,
    output word_t              mtvalVal,
    output word_t              mscratchVal,
    output word_t              mieVal,
    output word_t              mipVal,
    output word_t              mcounterenVal,
    output word_t              retVec,
    output word_t              trapVecBase,
    output logic               irqPending,
    output logic [CAUSE_W-1:0] irqCause
);

    logic irqEnabled;
    logic trapTaken;
    logic mtip;
    logic meip;
    word_t pend;
    word_t tvalSel;

    assign irqEnabled = (priv == privUser) || mstatusMie;
    assign trapTaken = trapValid && (!trapIsInterrupt || irqEnabled);
    assign trapVecBase = mtvecVal;

    always_comb begin
        tvalSel = '0;  // interrupts and other causes
        if (!trapIsInterrupt) begin
            case (trapCause)
                CAUSE_FETCH_AF, CAUSE_FETCH_PF, CAUSE_BREAK: tvalSel = trapPc;
                CAUSE_LOAD_MA, CAUSE_LOAD_AF, CAUSE_LOAD_PF,
                CAUSE_STORE_MA, CAUSE_STORE_AF, CAUSE_STORE_PF: tvalSel = trapTval;
                default: ;
            endcase
        end
    end

    always_comb begin
        mipVal = '0;
        mipVal[MTI_BIT] = mtip;
        mipVal[MEI_BIT] = meip;
    end

    assign pend = mipVal & mieVal;

    // external beats timer
    always_comb begin
        irqPending = 1'b0;
        irqCause = '0;
        if (irqEnabled && pend[MEI_BIT]) begin
            irqPending = 1'b1;
            irqCause = CAUSE_W'(MEI_BIT);
        end else if (irqEnabled && pend[MTI_BIT]) begin
            irqPending = 1'b1;
            irqCause = CAUSE_W'(MTI_BIT);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mtvecVal <= RESET_VECTOR;
            mepcVal <= '0;
            mcauseVal <= '0;
            mtvalVal <= '0;
            mscratchVal <= '0;
            mieVal <= '0;
            mcounterenVal <= '0;
            retVec <= '0;
            mtip <= 1'b0;
            meip <= 1'b0;
        end else begin
            mtip <= irqTimer;
            meip <= irqExt;
            if (trapTaken) begin
                mepcVal <= {trapPc[XLEN-1:1], 1'b0};
                mcauseVal <= {trapIsInterrupt, {(XLEN-1-CAUSE_W){1'b0}}, trapCause};
                mtvalVal <= tvalSel;
            end else if (wrEn) begin
                case (wrAddr)
                    csrMtvec: mtvecVal <= {wrData[XLEN-1:2], 2'b00};  // direct mode only
                    csrMepc: mepcVal <= {wrData[XLEN-1:1], 1'b0};
                    csrMcause: begin
                        mcauseVal <= {wrData[XLEN-1], {(XLEN-1-CAUSE_W){1'b0}},
                                      wrData[CAUSE_W-1:0]};
                    end
                    csrMtval: mtvalVal <= wrData;
                    csrMscratch: mscratchVal <= wrData;
                    csrMie: mieVal <= wrData & IRQ_MASK;
                    csrMcounteren: mcounterenVal <= wrData;
                    default: ;
                endcase
            end
            if (mretEn)
                retVec <= mepcVal;
        end
    end

endmodule

`default_nettype wire

/* src/csrAccess.sv */
`timescale 1ns/1ps
`default_nettype none

module csrAccess import csrPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       opValid,
    input  csrOp_e     opCode,
    input  csrAddr_t   opAddr,
    input  word_t      opSrc,
    input  logic [4:0] opImm,
    input  privLevel_e priv,
    input  word_t      mstatusVal,
    input  word_t      mtvecVal,
    input  word_t      mepcVal,
    input  word_t      mcauseVal,
    input  word_t      mtvalVal,
    input  word_t      mscratchVal,
    input  word_t      mieVal,
    input  word_t      mipVal,
    input  word_t      mcounterenVal,
    input  logic [1:0] inhibit,
    input  logic [63:0] mcycle,
    input  logic [63:0] minstret,
    output logic       wrEn,
    output csrAddr_t   wrAddr,
    output word_t      wrData,
    output logic       mretEn,
    output logic       resValid,
    output resFlags_e  resFlags,
    output word_t      resData
);

    word_t oldVal;
    word_t operand;
    logic unknownAddr;
    logic counterDenied;
    logic userNoCy;
    logic userNoIr;
    logic isMret;
    logic isWrite;
    logic illegal;
    logic ordering;

    assign userNoCy = (priv == privUser) && !mcounterenVal[CY_BIT];
    assign userNoIr = (priv == privUser) && !mcounterenVal[IR_BIT];

    always_comb begin
        oldVal = '0;
        unknownAddr = 1'b0;
        counterDenied = 1'b0;
        case (opAddr)
            csrMstatus: oldVal = mstatusVal;
            csrMie: oldVal = mieVal;
            csrMtvec: oldVal = mtvecVal;
            csrMcounteren: oldVal = mcounterenVal;
            csrMcountinhibit: oldVal = {{(XLEN-3){1'b0}}, inhibit[1], 1'b0, inhibit[0]};
            csrMscratch: oldVal = mscratchVal;
            csrMepc: oldVal = mepcVal;
            csrMcause: oldVal = mcauseVal;
            csrMtval: oldVal = mtvalVal;
            csrMip: oldVal = mipVal;
            csrMcycle: oldVal = mcycle[XLEN-1:0];
            csrMcycleh: oldVal = mcycle[63:XLEN];
            csrMinstret: oldVal = minstret[XLEN-1:0];
            csrMinstreth: oldVal = minstret[63:XLEN];
            csrCycle, csrCycleh: begin
                oldVal = (opAddr == csrCycle) ? mcycle[XLEN-1:0] : mcycle[63:XLEN];
                counterDenied = userNoCy;
            end
            csrInstret, csrInstreth: begin
                oldVal = (opAddr == csrInstret) ? minstret[XLEN-1:0] : minstret[63:XLEN];
                counterDenied = userNoIr;
            end
            default: unknownAddr = 1'b1;
        endcase
    end

    assign isMret = (opCode == opMret);
    assign isWrite = !isMret && (opCode != opRead);
    assign operand = (opCode inside {opReadWriteImm, opReadSetImm, opReadClearImm})
                   ? XLEN'(opImm) : opSrc;

    // mret ignores the address
    assign illegal = isMret ? (priv == privUser)
                            : (unknownAddr || (opAddr[9:8] > priv) || counterDenied
                               || (isWrite && opAddr[11:10] == 2'b11));

    always_comb begin
        case (opCode)
            opReadWrite, opReadWriteImm: wrData = operand;
            opReadSet, opReadSetImm: wrData = oldVal | operand;
            opReadClear, opReadClearImm: wrData = oldVal & ~operand;
            default: wrData = oldVal;
        endcase
    end

    assign wrEn = opValid && isWrite && !illegal;
    assign wrAddr = opAddr;
    assign mretEn = opValid && isMret && !illegal;
    // these feed other pipeline stages
    assign ordering = opAddr inside {csrMstatus, csrMie, csrMip, csrMcounteren};

    always_ff @(posedge clk) begin
        if (rst)
            resValid <= 1'b0;
        else
            resValid <= opValid;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resFlags <= flagsNone;
            resData <= '0;
        end else if (opValid) begin
            resData <= (illegal || isMret) ? '0 : oldVal;
            if (illegal)
                resFlags <= flagsIllegal;
            else if (isMret)
                resFlags <= flagsXret;
            else if (isWrite && ordering)
                resFlags <= flagsOrdering;
            else
                resFlags <= flagsNone;
        end
    end

endmodule

`default_nettype wire

/* src/csrUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module csrUnit import csrPkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                opValid,
    input  csrOp_e              opCode,
    input  csrAddr_t            opAddr,
    input  word_t               opSrc,
    input  logic [4:0]          opImm,
    output logic                resValid,
    output resFlags_e           resFlags,
    output word_t               resData,
    input  logic                trapValid,
    input  logic [CAUSE_W-1:0]  trapCause,
    input  logic                trapIsInterrupt,
    input  word_t               trapPc,
    input  word_t               trapTval,
    input  logic [RETIRE_W-1:0] retireCount,
    input  logic                irqExt,
    input  logic                irqTimer,
    output privLevel_e          priv,
    output word_t               retVec,
    output word_t               trapVecBase,
    output logic                irqPending,
    output logic [CAUSE_W-1:0]  irqCause
);

    logic wrEn;
    csrAddr_t wrAddr;
    word_t wrData;
    logic mretEn;
    logic mstatusMie;
    word_t mstatusVal;
    word_t mtvecVal;
    word_t mepcVal;
    word_t mcauseVal;
    word_t mtvalVal;
    word_t mscratchVal;
    word_t mieVal;
    word_t mipVal;
    word_t mcounterenVal;
    logic [1:0] inhibit;
    logic [63:0] mcycle;
    logic [63:0] minstret;

    privControl privControl_i (
        .clk(clk), .rst(rst),
        .trapValid(trapValid), .trapIsInterrupt(trapIsInterrupt), .mretEn(mretEn),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
        .priv(priv), .mstatusMie(mstatusMie), .mstatusVal(mstatusVal)
    );

    cycleCounters cycleCounters_i (
        .clk(clk), .rst(rst), .retireCount(retireCount),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
        .inhibit(inhibit), .mcycle(mcycle), .minstret(minstret)
    );

    trapRegs trapRegs_i (
        .clk(clk), .rst(rst),
        .trapValid(trapValid), .trapCause(trapCause), .trapIsInterrupt(trapIsInterrupt),
        .trapPc(trapPc), .trapTval(trapTval), .irqExt(irqExt), .irqTimer(irqTimer),
        .mretEn(mretEn), .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData),
        .priv(priv), .mstatusMie(mstatusMie),
        .mtvecVal(mtvecVal), .mepcVal(mepcVal), .mcauseVal(mcauseVal), .mtvalVal(mtvalVal),
        .mscratchVal(mscratchVal), .mieVal(mieVal), .mipVal(mipVal),
        .mcounterenVal(mcounterenVal), .retVec(retVec), .trapVecBase(trapVecBase),
        .irqPending(irqPending), .irqCause(irqCause)
    );

    csrAccess csrAccess_i (
        .clk(clk), .rst(rst),
        .opValid(opValid), .opCode(opCode), .opAddr(opAddr), .opSrc(opSrc), .opImm(opImm),
        .priv(priv), .mstatusVal(mstatusVal), .mtvecVal(mtvecVal), .mepcVal(mepcVal),
        .mcauseVal(mcauseVal), .mtvalVal(mtvalVal), .mscratchVal(mscratchVal),
        .mieVal(mieVal), .mipVal(mipVal), .mcounterenVal(mcounterenVal),
        .inhibit(inhibit), .mcycle(mcycle), .minstret(minstret),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData), .mretEn(mretEn),
        .resValid(resValid), .resFlags(resFlags), .resData(resData)
    );

endmodule

`default_nettype wire

/* tb/csrUnitTb.sv */
`timescale 1ns/1ps
`default_nettype none

module csrUnitTb import csrPkg::*; ();

    localparam int VEC_WORDS = 8;  // kind plus seven fields
    localparam int MAX_VEC = 64;

    logic clk;
    logic rst;
    logic opValid;
    csrOp_e opCode;
    csrAddr_t opAddr;
    word_t opSrc;
    logic [4:0] opImm;
    logic resValid;
    resFlags_e resFlags;
    word_t resData;
    logic trapValid;
    logic [CAUSE_W-1:0] trapCause;
    logic trapIsInterrupt;
    word_t trapPc;
    word_t trapTval;
    logic [RETIRE_W-1:0] retireCount;
    logic irqExt;
    logic irqTimer;
    privLevel_e priv;
    word_t retVec;
    word_t trapVecBase;
    logic irqPending;
    logic [CAUSE_W-1:0] irqCause;

    logic [31:0] vecMem [0:MAX_VEC*VEC_WORDS-1];
    int cycleCount = 0;
    int cycleLimit = 50;

    csrUnit dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit)
            abortRun("timeout: the vectors did not finish within the cycle limit");
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic checkResValid(input logic expValid);
        if (resValid !== expValid)
            abortRun($sformatf("ERROR: resValid got %h expected %h", resValid, expValid));
    endtask

    task automatic checkFlags(input resFlags_e expFlags);
        if (resFlags !== expFlags)
            abortRun($sformatf("ERROR: resFlags got %h expected %h", resFlags, expFlags));
    endtask

    task automatic checkResult(input resFlags_e expFlags, input word_t expData);
        if (resFlags !== expFlags)
            abortRun($sformatf("ERROR: resFlags got %h expected %h", resFlags, expFlags));
        else if (resData !== expData)
            abortRun($sformatf("ERROR: resData got %h expected %h", resData, expData));
    endtask

    task automatic checkPriv(input privLevel_e expPriv);
        if (priv !== expPriv)
            abortRun($sformatf("ERROR: priv got %h expected %h", priv, expPriv));
    endtask

    task automatic checkIrq(input logic expPending, input logic [CAUSE_W-1:0] expCause);
        if (irqPending !== expPending)
            abortRun($sformatf("ERROR: irqPending got %h expected %h", irqPending, expPending));
        else if (irqCause !== expCause)
            abortRun($sformatf("ERROR: irqCause got %h expected %h", irqCause, expCause));
    endtask

    task automatic checkRetVec(input word_t expVec);
        if (retVec !== expVec)
            abortRun($sformatf("ERROR: retVec got %h expected %h", retVec, expVec));
    endtask

    task automatic checkTrapVecBase(input word_t expBase);
        if (trapVecBase !== expBase)
            abortRun($sformatf("ERROR: trapVecBase got %h expected %h", trapVecBase, expBase));
    endtask

    // one op, result is registered a cycle later
    task automatic runOp(input int base, input logic withData);
        @(negedge clk);
        checkResValid(1'b0);  // previous result lasted one cycle
        opValid = 1'b1;
        opCode = csrOp_e'(vecMem[base+1][2:0]);
        opAddr = vecMem[base+2][CSR_ADDR_W-1:0];
        opSrc = vecMem[base+3];
        opImm = vecMem[base+4][4:0];
        @(negedge clk);
        opValid = 1'b0;
        checkResValid(1'b1);
        if (withData)
            checkResult(resFlags_e'(vecMem[base+5][1:0]), vecMem[base+6]);
        else
            checkFlags(resFlags_e'(vecMem[base+5][1:0]));  // counter still running
        checkPriv(privLevel_e'(vecMem[base+7][1:0]));
        // trap base follows mtvec
        if (withData && opCode == opRead && opAddr == csrMtvec
            && resFlags_e'(vecMem[base+5][1:0]) == flagsNone)
            checkTrapVecBase(vecMem[base+6]);
    endtask

    task automatic runTrap(input int base);
        @(negedge clk);
        trapValid = 1'b1;
        trapCause = vecMem[base+1][CAUSE_W-1:0];
        trapIsInterrupt = vecMem[base+2][0];
        trapPc = vecMem[base+3];
        trapTval = vecMem[base+4];
        @(negedge clk);
        trapValid = 1'b0;
        checkPriv(privLevel_e'(vecMem[base+5][1:0]));
    endtask

    task automatic runIrq(input int base);
        @(negedge clk);
        irqExt = vecMem[base+1][0];
        irqTimer = vecMem[base+2][0];
        @(negedge clk);  // mip takes a cycle
        checkIrq(vecMem[base+3][0], vecMem[base+4][CAUSE_W-1:0]);
    endtask

    task automatic runRetire(input int base);
        @(negedge clk);
        retireCount = vecMem[base+1][RETIRE_W-1:0];
        repeat (vecMem[base+2]) @(negedge clk);
        retireCount = '0;
    endtask

    initial begin
        int numVec;
        int base;
        int kind;
        int i;
        rst = 1'b1;
        opValid = 1'b0;
        opCode = opRead;
        opAddr = '0;
        opSrc = '0;
        opImm = '0;
        trapValid = 1'b0;
        trapCause = '0;
        trapIsInterrupt = 1'b0;
        trapPc = '0;
        trapTval = '0;
        retireCount = '0;
        irqExt = 1'b0;
        irqTimer = 1'b0;
        $readmemh("tb/csrVectors.txt", vecMem);
        numVec = 0;
        while (numVec < MAX_VEC && vecMem[numVec*VEC_WORDS] != 0)
            numVec++;
        cycleLimit = 40 * numVec + 50;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        // state straight out of reset
        checkResValid(1'b0);
        checkResult(flagsNone, '0);
        checkPriv(privMachine);
        checkTrapVecBase(RESET_VECTOR);
        checkRetVec('0);
        checkIrq(1'b0, '0);
        for (i = 0; i < numVec; i++) begin
            base = i * VEC_WORDS;
            kind = vecMem[base];
            case (kind)
                1: runOp(base, 1'b1);
                2: runTrap(base);
                3: runIrq(base);
                4: runRetire(base);
                5: checkRetVec(vecMem[base+1]);
                6: runOp(base, 1'b0);
                default: abortRun($sformatf("vector %0d has unknown kind %0d", i, kind));
            endcase
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* tb/csrVectors.txt */
// kind 1 op (6 op, data unchecked): opCode addr src imm expFlags expData expPriv
// kind 2 trap: cause isInt pc tval expPriv, 3 irq: ext timer expPending expCause
// kind 4 retire: count cycles, 5 retVec: expected value, 0 ends the list
1 1 340 12345678 00 0 00000000 3
1 2 340 0000ff00 00 0 12345678 3
1 5 340 00000000 05 0 1234ff78 3
1 6 340 00000000 1f 0 1234ff7d 3
1 0 340 00000000 00 0 1234ff60 3
1 1 305 00001237 00 0 80000000 3
1 0 305 00000000 00 0 00001234 3
1 1 300 00000000 00 1 00000000 3
1 1 320 00000005 00 0 00000000 3
6 1 b00 00000100 00 0 00000000 3
1 1 b02 00001000 00 0 00000000 3
1 0 b00 00000000 00 0 00000100 3
1 1 320 00000001 00 0 00000005 3
4 2 3 0 0 0 0 0
4 1 1 0 0 0 0 0
1 1 320 00000005 00 0 00000001 3
1 0 b02 00000000 00 0 00001007 3
1 0 b00 00000000 00 0 00000100 3
2 5 0 80000105 0000abcd 3 0 0
1 0 341 00000000 00 0 80000104 3
1 0 342 00000000 00 0 00000005 3
1 0 343 00000000 00 0 0000abcd 3
1 0 300 00000000 00 0 00001800 3
1 1 300 00000000 00 1 00001800 3
1 7 000 00000000 00 2 00000000 0
5 80000104 0 0 0 0 0 0
1 0 340 00000000 00 3 00000000 0
1 1 c00 00000000 00 3 00000000 0
1 0 c00 00000000 00 3 00000000 0
1 7 000 00000000 00 3 00000000 0
2 8 0 00000200 ffffffff 3 0 0
1 0 343 00000000 00 0 00000000 3
1 5 306 00000000 01 1 00000000 3
1 7 000 00000000 00 2 00000000 0
5 00000200 0 0 0 0 0 0
1 0 c00 00000000 00 0 00000100 0
1 0 c02 00000000 00 3 00000000 0
2 2 0 00000300 00000000 3 0 0
1 1 304 ffffffff 00 1 00000000 3
1 0 304 00000000 00 0 00000888 3
3 0 1 0 0 0 0 0
1 0 344 00000000 00 0 00000080 3
1 5 300 00000000 08 1 00000000 3
3 0 1 1 7 0 0 0
3 1 1 1 b 0 0 0
1 6 300 00000000 08 1 00000008 3
3 1 1 0 0 0 0 0
1 7 000 00000000 00 2 00000000 0
3 1 1 1 b 0 0 0
0 0 0 0 0 0 0 0

/* src.f */
src/csrPkg.sv
src/privControl.sv
src/cycleCounters.sv
src/trapRegs.sv
src/csrAccess.sv
src/csrUnit.sv
tb/csrUnitTb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the csrUnit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module csrUnitTb -o csrUnitSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/csrUnitSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qFx "Test completed successfully"; then
    exit 0
else
    exit 1
fi
